//--- verilog/mrd_pkg.sv
// Shared widths, packet limits, pipeline latencies and the memory FSM state type
`default_nettype none

package mrd_pkg;

	// ----------------------------------------
	// Data path
	// ----------------------------------------
	// One real or imaginary part in two's complement
	localparam int W_DATA = 18;

	// ----------------------------------------
	// Packet geometry
	// ----------------------------------------
	// Largest packet holds 2**MAX_LOG samples
	localparam int MAX_LOG = 6;
	// Sample index inside a packet
	localparam int W_IDX = 6;
	// Address inside one bank is the index without bit 0
	localparam int W_ADDR = 5;
	// Holds log2(N) from 2 to 6
	localparam int W_LOG = 3;

	// ----------------------------------------
	// Timing
	// ----------------------------------------
	// Idle cycles in Sink before the packet is dropped
	localparam int SINK_TIMEOUT = 32;
	// Butterfly pipeline depth
	localparam int CORE_LATENCY = 2;
	// Bank read from address to data
	localparam int RD_LATENCY = 1;

	// Memory FSM
	typedef enum logic [2:0] {
		ST_IDLE        = 3'd0,
		ST_SINK        = 3'd1,
		ST_RD          = 3'd2,
		ST_WAIT_WR_END = 3'd3,
		ST_SOURCE      = 3'd4
	} mem_state_t;

endpackage

`default_nettype wire

//--- verilog/mrd_ram_bank.sv
// Simple dual-port sample bank with one write and one registered read per cycle
`timescale 1ns/100ps
`default_nettype none

module mrd_ram_bank (
	input  wire                        clk,
	input  wire                        wr_en,
	input  wire  [mrd_pkg::W_ADDR-1:0] wr_addr,
	input  wire  [mrd_pkg::W_DATA-1:0] wr_real,
	input  wire  [mrd_pkg::W_DATA-1:0] wr_imag,
	input  wire                        rd_en,
	input  wire  [mrd_pkg::W_ADDR-1:0] rd_addr,
	output logic [mrd_pkg::W_DATA-1:0] rd_real,
	output logic [mrd_pkg::W_DATA-1:0] rd_imag
);
	import mrd_pkg::*;

	// Real part in the upper half of each word
	logic [2*W_DATA-1:0] mem [1 << W_ADDR];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= {wr_real, wr_imag};
		end
	end

	// Output holds between read enables
	always_ff @(posedge clk) begin
		if (rd_en) begin
			{rd_real, rd_imag} <= mem[rd_addr];
		end
	end

	// The sequencing never reads a word in the cycle it is rewritten
	a_no_rw_collision: assert property (@(posedge clk)
		!(wr_en && rd_en && (wr_addr == rd_addr)))
		else $error("bank read and write at address %0d in one cycle", rd_addr);

endmodule

`default_nettype wire

//--- verilog/mrd_sink_agu.sv
// Sink address generator with sample counter, parity bank mapping and idle timeout
`timescale 1ns/100ps
`default_nettype none

module mrd_sink_agu (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        active,
	input  wire                        in_valid,
	input  wire  [mrd_pkg::W_LOG-1:0]  size_log,
	output logic                       wr_en,
	output logic                       wr_bank,
	output logic [mrd_pkg::W_ADDR-1:0] wr_addr,
	output logic                       sink_done,
	output logic                       over_time
);
	import mrd_pkg::*;

	logic [W_IDX-1:0]                cnt;
	logic [W_IDX-1:0]                last_idx;
	logic [$clog2(SINK_TIMEOUT)-1:0] idle_cnt;
	logic                            accept;

	assign accept = active && in_valid;

	// N-1 is a mask of size_log ones
	assign last_idx  = {W_IDX{1'b1}} >> (MAX_LOG - size_log);
	assign sink_done = accept && (cnt == last_idx);
	assign over_time = active && !in_valid && (idle_cnt == SINK_TIMEOUT - 1);

	// Sample and idle counters
	// Both restart whenever the sink is not active
	always_ff @(posedge clk) begin
		if (!rst_n || !active) begin
			cnt      <= '0;
			idle_cnt <= '0;
		end else if (in_valid) begin
			cnt      <= cnt + 1'b1;
			idle_cnt <= '0;
		end else begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	// ----------------------------------------
	// Write port
	// ----------------------------------------
	// One cycle late to line up with the input data register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_en <= 1'b0;
		end else begin
			wr_en <= accept;
		end
	end

	// Bank by XOR parity of the index
	always_ff @(posedge clk) begin
		wr_bank <= ^cnt;
		wr_addr <= cnt[W_IDX-1:1];
	end

endmodule

`default_nettype wire

//--- verilog/mrd_stage_rd.sv
// Butterfly pair generator and read-side bank addressing for one stage
`timescale 1ns/100ps
`default_nettype none

module mrd_stage_rd (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        start,
	input  wire  [mrd_pkg::W_LOG-1:0]  stage,
	input  wire  [mrd_pkg::W_LOG-1:0]  size_log,
	output logic                       issue,
	output logic [mrd_pkg::W_IDX-1:0]  idx_a,
	output logic [mrd_pkg::W_IDX-1:0]  idx_b,
	output logic                       rd_en,
	output logic [mrd_pkg::W_ADDR-1:0] rd_addr_0,
	output logic [mrd_pkg::W_ADDR-1:0] rd_addr_1,
	output logic                       swap,
	output logic                       rd_end
);
	import mrd_pkg::*;

	logic [W_IDX-2:0] pair_cnt;
	logic [W_IDX-2:0] last_pair;
	logic [W_LOG-1:0] span_pos;
	logic [W_IDX-1:0] low_mask;
	logic [W_IDX-1:0] pair_ext;
	logic             a_in_bank1;

	// start stays high for the whole read phase
	// One pair leaves per cycle
	assign issue = start;
	assign rd_en = start;

	// ----------------------------------------
	// Pair index
	// ----------------------------------------
	// Span is N >> (stage+1) so its bit sits at log2(N)-1-stage
	assign span_pos  = size_log - stage - 1'b1;
	assign low_mask  = (W_IDX'(1) << span_pos) - 1'b1;
	assign pair_ext  = {1'b0, pair_cnt};
	assign last_pair = {(W_IDX-1){1'b1}} >> (MAX_LOG - size_log);

	// Zero inserted at the span bit
	assign idx_a = ((pair_ext & ~low_mask) << 1) | (pair_ext & low_mask);
	assign idx_b = idx_a | (low_mask + 1'b1);

	assign rd_end = start && (pair_cnt == last_pair);

	always_ff @(posedge clk) begin
		if (!rst_n || !start) begin
			pair_cnt <= '0;
		end else begin
			pair_cnt <= pair_cnt + 1'b1;
		end
	end

	// ----------------------------------------
	// Bank addressing
	// ----------------------------------------
	// Pair members differ in one bit
	// so they always sit in opposite banks
	assign a_in_bank1 = ^idx_a;
	assign rd_addr_0  = a_in_bank1 ? idx_b[W_IDX-1:1] : idx_a[W_IDX-1:1];
	assign rd_addr_1  = a_in_bank1 ? idx_a[W_IDX-1:1] : idx_b[W_IDX-1:1];

	// Operand routing follows the bank read by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			swap <= 1'b0;
		end else begin
			swap <= a_in_bank1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mrd_stage_wr.sv
// Pair index delay line and write-back bank addressing for butterfly results
`timescale 1ns/100ps
`default_nettype none

module mrd_stage_wr (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        issue,
	input  wire  [mrd_pkg::W_IDX-1:0]  idx_a,
	input  wire  [mrd_pkg::W_IDX-1:0]  idx_b,
	input  wire                        res_valid,
	input  wire  [mrd_pkg::W_DATA-1:0] res_a_real,
	input  wire  [mrd_pkg::W_DATA-1:0] res_a_imag,
	input  wire  [mrd_pkg::W_DATA-1:0] res_b_real,
	input  wire  [mrd_pkg::W_DATA-1:0] res_b_imag,
	output logic                       wr_en,
	output logic [mrd_pkg::W_ADDR-1:0] wr_addr_0,
	output logic [mrd_pkg::W_ADDR-1:0] wr_addr_1,
	output logic [mrd_pkg::W_DATA-1:0] wr_real_0,
	output logic [mrd_pkg::W_DATA-1:0] wr_imag_0,
	output logic [mrd_pkg::W_DATA-1:0] wr_real_1,
	output logic [mrd_pkg::W_DATA-1:0] wr_imag_1,
	input  wire                        last_issue,
	output logic                       wr_end
);
	import mrd_pkg::*;

	// One slot per cycle of bank read plus core
	logic [RD_LATENCY+CORE_LATENCY-1:0] vld_d;
	logic [RD_LATENCY+CORE_LATENCY-1:0] last_d;
	logic [W_IDX-1:0] a_d [RD_LATENCY+CORE_LATENCY];
	logic [W_IDX-1:0] b_d [RD_LATENCY+CORE_LATENCY];
	logic [W_IDX-1:0] wa;
	logic [W_IDX-1:0] wb;
	logic             a_in_bank1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_d  <= '0;
			last_d <= '0;
		end else begin
			vld_d  <= {vld_d[RD_LATENCY+CORE_LATENCY-2:0], issue};
			last_d <= {last_d[RD_LATENCY+CORE_LATENCY-2:0], last_issue};
		end
	end

	// Several pairs in flight at once
	always_ff @(posedge clk) begin
		a_d[0] <= idx_a;
		b_d[0] <= idx_b;
		for (int i = 1; i < RD_LATENCY + CORE_LATENCY; i++) begin
			a_d[i] <= a_d[i-1];
			b_d[i] <= b_d[i-1];
		end
	end

	assign wa = a_d[RD_LATENCY+CORE_LATENCY-1];
	assign wb = b_d[RD_LATENCY+CORE_LATENCY-1];

	// Each result goes back to the bank that owns its index
	assign a_in_bank1 = ^wa;
	assign wr_en      = res_valid;
	assign wr_addr_0  = a_in_bank1 ? wb[W_IDX-1:1] : wa[W_IDX-1:1];
	assign wr_addr_1  = a_in_bank1 ? wa[W_IDX-1:1] : wb[W_IDX-1:1];
	assign wr_real_0  = a_in_bank1 ? res_b_real : res_a_real;
	assign wr_imag_0  = a_in_bank1 ? res_b_imag : res_a_imag;
	assign wr_real_1  = a_in_bank1 ? res_a_real : res_b_real;
	assign wr_imag_1  = a_in_bank1 ? res_a_imag : res_b_imag;

	assign wr_end = res_valid && last_d[RD_LATENCY+CORE_LATENCY-1];

	// Core output must line up with the delayed pair indices
	a_res_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid == vld_d[RD_LATENCY+CORE_LATENCY-1])
		else $error("butterfly result out of step with issued pair");

endmodule

`default_nettype wire

//--- verilog/mrd_rdx2_core.sv
// Two-cycle radix-2 butterfly with halved sum and difference outputs
`timescale 1ns/100ps
`default_nettype none

module mrd_rdx2_core (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        bf_valid,
	input  wire  [mrd_pkg::W_DATA-1:0] bf_a_real,
	input  wire  [mrd_pkg::W_DATA-1:0] bf_a_imag,
	input  wire  [mrd_pkg::W_DATA-1:0] bf_b_real,
	input  wire  [mrd_pkg::W_DATA-1:0] bf_b_imag,
	output logic                       res_valid,
	output logic [mrd_pkg::W_DATA-1:0] res_a_real,
	output logic [mrd_pkg::W_DATA-1:0] res_a_imag,
	output logic [mrd_pkg::W_DATA-1:0] res_b_real,
	output logic [mrd_pkg::W_DATA-1:0] res_b_imag
);
	import mrd_pkg::*;

	// One guard bit so the sum cannot overflow
	logic [W_DATA:0] sum_re;
	logic [W_DATA:0] sum_im;
	logic [W_DATA:0] dif_re;
	logic [W_DATA:0] dif_im;
	logic            s1_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			s1_valid  <= bf_valid;
			res_valid <= s1_valid;
		end
	end

	// Stage 1 with sign-extended operands
	always_ff @(posedge clk) begin
		sum_re <= {bf_a_real[W_DATA-1], bf_a_real} + {bf_b_real[W_DATA-1], bf_b_real};
		sum_im <= {bf_a_imag[W_DATA-1], bf_a_imag} + {bf_b_imag[W_DATA-1], bf_b_imag};
		dif_re <= {bf_a_real[W_DATA-1], bf_a_real} - {bf_b_real[W_DATA-1], bf_b_real};
		dif_im <= {bf_a_imag[W_DATA-1], bf_a_imag} - {bf_b_imag[W_DATA-1], bf_b_imag};
	end

	// Stage 2 drops bit 0 as an arithmetic halving
	always_ff @(posedge clk) begin
		res_a_real <= sum_re[W_DATA:1];
		res_a_imag <= sum_im[W_DATA:1];
		res_b_real <= dif_re[W_DATA:1];
		res_b_imag <= dif_im[W_DATA:1];
	end

endmodule

`default_nettype wire

//--- verilog/mrd_source_agu.sv
// Source address generator for natural-order readout and output framing
`timescale 1ns/100ps
`default_nettype none

module mrd_source_agu (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        start,
	input  wire  [mrd_pkg::W_LOG-1:0]  size_log,
	output logic                       rd_en,
	output logic [mrd_pkg::W_ADDR-1:0] rd_addr,
	output logic                       rd_bank,
	output logic                       out_valid,
	output logic                       out_sop,
	output logic                       out_eop,
	output logic                       source_end
);
	import mrd_pkg::*;

	logic [W_IDX-1:0] idx;
	logic [W_IDX-1:0] last_idx;
	logic             valid_d;
	logic             sop_d;
	logic             eop_d;

	assign last_idx = {W_IDX{1'b1}} >> (MAX_LOG - size_log);

	// Both banks read at the same address
	// and the owning bank is picked afterwards
	assign rd_en      = start;
	assign rd_addr    = idx[W_IDX-1:1];
	assign source_end = start && (idx == last_idx);

	always_ff @(posedge clk) begin
		if (!rst_n || !start) begin
			idx <= '0;
		end else begin
			idx <= idx + 1'b1;
		end
	end

	// ----------------------------------------
	// Framing pipeline
	// ----------------------------------------
	// First register matches the bank read
	// second one matches the output data register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_d   <= 1'b0;
			sop_d     <= 1'b0;
			eop_d     <= 1'b0;
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
		end else begin
			valid_d   <= start;
			sop_d     <= start && (idx == '0);
			eop_d     <= source_end;
			out_valid <= valid_d;
			out_sop   <= sop_d;
			out_eop   <= eop_d;
		end
	end

	// Bank select valid while the read data is on the bank outputs
	always_ff @(posedge clk) begin
		rd_bank <= ^idx;
	end

endmodule

`default_nettype wire

//--- verilog/mrd_mem_top.sv
// Memory top with FSM, stage counter, bank port switches and the two banks
`timescale 1ns/100ps
`default_nettype none

module mrd_mem_top (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        in_valid,
	input  wire                        in_sop,
	input  wire  [mrd_pkg::W_LOG-1:0]  in_size_log,
	input  wire  [mrd_pkg::W_DATA-1:0] in_real,
	input  wire  [mrd_pkg::W_DATA-1:0] in_imag,
	output logic                       sink_ready,
	output mrd_pkg::mem_state_t        state,
	output logic                       bf_valid,
	output logic [mrd_pkg::W_DATA-1:0] bf_a_real,
	output logic [mrd_pkg::W_DATA-1:0] bf_a_imag,
	output logic [mrd_pkg::W_DATA-1:0] bf_b_real,
	output logic [mrd_pkg::W_DATA-1:0] bf_b_imag,
	input  wire                        res_valid,
	input  wire  [mrd_pkg::W_DATA-1:0] res_a_real,
	input  wire  [mrd_pkg::W_DATA-1:0] res_a_imag,
	input  wire  [mrd_pkg::W_DATA-1:0] res_b_real,
	input  wire  [mrd_pkg::W_DATA-1:0] res_b_imag,
	output logic                       out_valid,
	output logic                       out_sop,
	output logic                       out_eop,
	output logic [mrd_pkg::W_DATA-1:0] out_real,
	output logic [mrd_pkg::W_DATA-1:0] out_imag
);
	import mrd_pkg::*;

	logic [W_LOG-1:0]  size_r;
	logic [W_LOG-1:0]  size_sel;
	logic [W_LOG-1:0]  stage;
	logic              last_stage;
	logic [W_DATA-1:0] in_real_r;
	logic [W_DATA-1:0] in_imag_r;

	// Sink unit
	logic              sink_active;
	logic              sink_wr_en;
	logic              sink_wr_bank;
	logic [W_ADDR-1:0] sink_wr_addr;
	logic              sink_done;
	logic              over_time;

	// Stage read and write units
	logic              stg_issue;
	logic              stg_rd_en;
	logic              stg_swap;
	logic              rd_end;
	logic [W_IDX-1:0]  idx_a;
	logic [W_IDX-1:0]  idx_b;
	logic [W_ADDR-1:0] stg_rd_addr [2];
	logic              stg_wr_en;
	logic              wr_end;
	logic [W_ADDR-1:0] stg_wr_addr [2];
	logic [W_DATA-1:0] stg_wr_real [2];
	logic [W_DATA-1:0] stg_wr_imag [2];

	// Source unit
	logic              src_rd_en;
	logic              src_bank;
	logic              source_end;
	logic [W_ADDR-1:0] src_rd_addr;

	// Bank ports after the switches
	logic              bank_wr_en   [2];
	logic [W_ADDR-1:0] bank_wr_addr [2];
	logic [W_DATA-1:0] bank_wr_real [2];
	logic [W_DATA-1:0] bank_wr_imag [2];
	logic              bank_rd_en   [2];
	logic [W_ADDR-1:0] bank_rd_addr [2];
	logic [W_DATA-1:0] q_real       [2];
	logic [W_DATA-1:0] q_imag       [2];

	// ----------------------------------------
	// FSM and stage counter
	// ----------------------------------------
	assign sink_ready  = (state == ST_IDLE);
	assign sink_active = ((state == ST_IDLE) && in_sop) || (state == ST_SINK);
	// Size is taken straight from the input on the sop sample
	assign size_sel    = (state == ST_IDLE) ? in_size_log : size_r;
	assign last_stage  = (stage == size_r - 1'b1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= ST_IDLE;
			stage  <= '0;
			size_r <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					stage <= '0;
					if (in_valid && in_sop) begin
						size_r <= in_size_log;
						state  <= ST_SINK;
					end
				end
				ST_SINK: begin
					if (sink_done) begin
						state <= ST_RD;
					end else if (over_time) begin
						state <= ST_IDLE;
					end
				end
				ST_RD: begin
					if (rd_end) begin
						state <= ST_WAIT_WR_END;
					end
				end
				// Next stage only after the last write of this one
				ST_WAIT_WR_END: begin
					if (wr_end && last_stage) begin
						state <= ST_SOURCE;
					end else if (wr_end) begin
						stage <= stage + 1'b1;
						state <= ST_RD;
					end
				end
				ST_SOURCE: begin
					if (source_end) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Input register in step with the sink write port
	always_ff @(posedge clk) begin
		in_real_r <= in_real;
		in_imag_r <= in_imag;
	end

	// ----------------------------------------
	// Bank port switches
	// ----------------------------------------
	// Last sink write lands in the first Rd cycle
	// so writes are switched by enable and not by state
	for (genvar b = 0; b < 2; b++) begin : g_bank
		assign bank_wr_en[b]   = sink_wr_en ? (sink_wr_bank == 1'(b)) : stg_wr_en;
		assign bank_wr_addr[b] = sink_wr_en ? sink_wr_addr : stg_wr_addr[b];
		assign bank_wr_real[b] = sink_wr_en ? in_real_r : stg_wr_real[b];
		assign bank_wr_imag[b] = sink_wr_en ? in_imag_r : stg_wr_imag[b];
		assign bank_rd_en[b]   = (state == ST_RD) ? stg_rd_en : src_rd_en;
		assign bank_rd_addr[b] = (state == ST_RD) ? stg_rd_addr[b] : src_rd_addr;

		mrd_ram_bank u_bank (
			.clk     (clk),
			.wr_en   (bank_wr_en[b]),
			.wr_addr (bank_wr_addr[b]),
			.wr_real (bank_wr_real[b]),
			.wr_imag (bank_wr_imag[b]),
			.rd_en   (bank_rd_en[b]),
			.rd_addr (bank_rd_addr[b]),
			.rd_real (q_real[b]),
			.rd_imag (q_imag[b])
		);
	end

	// Operands to the core
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bf_valid <= 1'b0;
		end else begin
			bf_valid <= stg_issue;
		end
	end

	assign bf_a_real = stg_swap ? q_real[1] : q_real[0];
	assign bf_a_imag = stg_swap ? q_imag[1] : q_imag[0];
	assign bf_b_real = stg_swap ? q_real[0] : q_real[1];
	assign bf_b_imag = stg_swap ? q_imag[0] : q_imag[1];

	// Output data register
	always_ff @(posedge clk) begin
		out_real <= src_bank ? q_real[1] : q_real[0];
		out_imag <= src_bank ? q_imag[1] : q_imag[0];
	end

	// ----------------------------------------
	// Address units
	// ----------------------------------------
	mrd_sink_agu u_sink (
		.clk       (clk),
		.rst_n     (rst_n),
		.active    (sink_active),
		.in_valid  (in_valid),
		.size_log  (size_sel),
		.wr_en     (sink_wr_en),
		.wr_bank   (sink_wr_bank),
		.wr_addr   (sink_wr_addr),
		.sink_done (sink_done),
		.over_time (over_time)
	);

	mrd_stage_rd u_stage_rd (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (state == ST_RD),
		.stage     (stage),
		.size_log  (size_r),
		.issue     (stg_issue),
		.idx_a     (idx_a),
		.idx_b     (idx_b),
		.rd_en     (stg_rd_en),
		.rd_addr_0 (stg_rd_addr[0]),
		.rd_addr_1 (stg_rd_addr[1]),
		.swap      (stg_swap),
		.rd_end    (rd_end)
	);

	mrd_stage_wr u_stage_wr (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (stg_issue),
		.idx_a      (idx_a),
		.idx_b      (idx_b),
		.res_valid  (res_valid),
		.res_a_real (res_a_real),
		.res_a_imag (res_a_imag),
		.res_b_real (res_b_real),
		.res_b_imag (res_b_imag),
		.wr_en      (stg_wr_en),
		.wr_addr_0  (stg_wr_addr[0]),
		.wr_addr_1  (stg_wr_addr[1]),
		.wr_real_0  (stg_wr_real[0]),
		.wr_imag_0  (stg_wr_imag[0]),
		.wr_real_1  (stg_wr_real[1]),
		.wr_imag_1  (stg_wr_imag[1]),
		.last_issue (rd_end),
		.wr_end     (wr_end)
	);

	mrd_source_agu u_source (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (state == ST_SOURCE),
		.size_log   (size_r),
		.rd_en      (src_rd_en),
		.rd_addr    (src_rd_addr),
		.rd_bank    (src_bank),
		.out_valid  (out_valid),
		.out_sop    (out_sop),
		.out_eop    (out_eop),
		.source_end (source_end)
	);

	// Sink fill and stage write-back never overlap
	a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
		!(sink_wr_en && stg_wr_en))
		else $error("sink and stage writer active in the same cycle");

endmodule

`default_nettype wire

//--- verilog/mrd_dft_top.sv
// Transform engine top joining the memory top and the radix-2 core
`timescale 1ns/100ps
`default_nettype none

module mrd_dft_top (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        in_valid,
	input  wire                        in_sop,
	input  wire  [mrd_pkg::W_LOG-1:0]  in_size_log,
	input  wire  [mrd_pkg::W_DATA-1:0] in_real,
	input  wire  [mrd_pkg::W_DATA-1:0] in_imag,
	output logic                       sink_ready,
	output mrd_pkg::mem_state_t        state,
	output logic                       out_valid,
	output logic                       out_sop,
	output logic                       out_eop,
	output logic [mrd_pkg::W_DATA-1:0] out_real,
	output logic [mrd_pkg::W_DATA-1:0] out_imag
);
	import mrd_pkg::*;

	// Operands to the core
	logic              bf_valid;
	logic [W_DATA-1:0] bf_a_real;
	logic [W_DATA-1:0] bf_a_imag;
	logic [W_DATA-1:0] bf_b_real;
	logic [W_DATA-1:0] bf_b_imag;

	// Results back to memory
	logic              res_valid;
	logic [W_DATA-1:0] res_a_real;
	logic [W_DATA-1:0] res_a_imag;
	logic [W_DATA-1:0] res_b_real;
	logic [W_DATA-1:0] res_b_imag;

	mrd_mem_top u_mem (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_sop      (in_sop),
		.in_size_log (in_size_log),
		.in_real     (in_real),
		.in_imag     (in_imag),
		.sink_ready  (sink_ready),
		.state       (state),
		.bf_valid    (bf_valid),
		.bf_a_real   (bf_a_real),
		.bf_a_imag   (bf_a_imag),
		.bf_b_real   (bf_b_real),
		.bf_b_imag   (bf_b_imag),
		.res_valid   (res_valid),
		.res_a_real  (res_a_real),
		.res_a_imag  (res_a_imag),
		.res_b_real  (res_b_real),
		.res_b_imag  (res_b_imag),
		.out_valid   (out_valid),
		.out_sop     (out_sop),
		.out_eop     (out_eop),
		.out_real    (out_real),
		.out_imag    (out_imag)
	);

	mrd_rdx2_core u_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.bf_valid   (bf_valid),
		.bf_a_real  (bf_a_real),
		.bf_a_imag  (bf_a_imag),
		.bf_b_real  (bf_b_real),
		.bf_b_imag  (bf_b_imag),
		.res_valid  (res_valid),
		.res_a_real (res_a_real),
		.res_a_imag (res_a_imag),
		.res_b_real (res_b_real),
		.res_b_imag (res_b_imag)
	);

endmodule

`default_nettype wire

//--- test/mrd_dft_tb.sv
// Transform engine testbench with directed tests, reference model, LCG and value checker
`timescale 1ns/100ps
`default_nettype none

module mrd_dft_tb;
	import mrd_pkg::*;

	// Cycle bounds for the wait loops
	localparam int DRAIN_LIMIT = 4000;
	localparam int READY_LIMIT = 4000;
	localparam int FULL_POS    = (1 << (W_DATA - 1)) - 1;
	localparam int FULL_NEG    = -(1 << (W_DATA - 1));

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	logic              in_sop;
	logic [W_LOG-1:0]  in_size_log;
	logic [W_DATA-1:0] in_real;
	logic [W_DATA-1:0] in_imag;
	logic              sink_ready;
	mem_state_t        state;
	logic              out_valid;
	logic              out_sop;
	logic              out_eop;
	logic [W_DATA-1:0] out_real;
	logic [W_DATA-1:0] out_imag;

	// Expected and captured output streams
	int exp_re [$];
	int exp_im [$];
	int exp_sop [$];
	int exp_eop [$];
	int got_re [$];
	int got_im [$];
	int got_sop [$];
	int got_eop [$];

	// Current packet in natural order
	int          pkt_re [64];
	int          pkt_im [64];
	logic [31:0] seed;
	int          err_count;
	int          check_count;

	mrd_dft_top UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_sop      (in_sop),
		.in_size_log (in_size_log),
		.in_real     (in_real),
		.in_imag     (in_imag),
		.sink_ready  (sink_ready),
		.state       (state),
		.out_valid   (out_valid),
		.out_sop     (out_sop),
		.out_eop     (out_eop),
		.out_real    (out_real),
		.out_imag    (out_imag)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Registered outputs captured at the falling edge
	always @(negedge clk) begin
		if (out_valid) begin
			got_re.push_back(int'($signed(out_real)));
			got_im.push_back(int'($signed(out_imag)));
			got_sop.push_back(int'(out_sop));
			got_eop.push_back(int'(out_eop));
		end
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic check_value(input string name, input int expected, input int actual);
		check_count++;
		if (expected != actual) begin
			err_count++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Upper bits of the LCG as one signed sample
	function automatic int rand_sample();
		logic [31:0] r;
		r = lcg_next();
		return int'($signed(r[31:32-W_DATA]));
	endfunction

	task automatic fill_random(input int log_n);
		for (int i = 0; i < (1 << log_n); i++) begin
			pkt_re[i] = rand_sample();
			pkt_im[i] = rand_sample();
		end
	endtask

	// Halving butterflies on a copy of the packet
	// Results go to the end of the expected stream
	task automatic model_packet(input int log_n);
		int n;
		int span;
		int a_re;
		int a_im;
		int b_re;
		int b_im;
		int x_re [64];
		int x_im [64];
		n = 1 << log_n;
		for (int i = 0; i < n; i++) begin
			x_re[i] = pkt_re[i];
			x_im[i] = pkt_im[i];
		end
		for (int s = 0; s < log_n; s++) begin
			span = n >> (s + 1);
			for (int j = 0; j < n; j++) begin
				if ((j & span) == 0) begin
					a_re = x_re[j];
					a_im = x_im[j];
					b_re = x_re[j+span];
					b_im = x_im[j+span];
					x_re[j]      = (a_re + b_re) >>> 1;
					x_im[j]      = (a_im + b_im) >>> 1;
					x_re[j+span] = (a_re - b_re) >>> 1;
					x_im[j+span] = (a_im - b_im) >>> 1;
				end
			end
		end
		for (int i = 0; i < n; i++) begin
			exp_re.push_back(x_re[i]);
			exp_im.push_back(x_im[i]);
			exp_sop.push_back(int'(i == 0));
			exp_eop.push_back(int'(i == n - 1));
		end
	endtask

	// Starts and ends on a falling edge
	// One sample per cycle
	task automatic send_packet(input int log_n, input int count);
		int wait_cnt;
		wait_cnt = 0;
		while (!sink_ready && wait_cnt < READY_LIMIT) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!sink_ready) begin
			err_count++;
			$display("Timeout: sink_ready stayed low, packet not sent");
			return;
		end
		for (int i = 0; i < count; i++) begin
			in_valid    = 1'b1;
			in_sop      = (i == 0);
			in_size_log = log_n[W_LOG-1:0];
			in_real     = pkt_re[i][W_DATA-1:0];
			in_imag     = pkt_im[i][W_DATA-1:0];
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_sop   = 1'b0;
		// Size input moves away so only the latched size can work
		in_size_log = ~log_n[W_LOG-1:0];
	endtask

	// Waits for all expected outputs
	// Junk goes onto the input when inject is set
	task automatic drain_and_check(input string name, input bit inject);
		int wait_cnt;
		int n_cmp;
		int junk;
		wait_cnt = 0;
		while (got_re.size() < exp_re.size() && wait_cnt < DRAIN_LIMIT) begin
			@(negedge clk);
			wait_cnt++;
			in_valid = 1'b0;
			// Junk only while the engine is busy
			if (inject && state != ST_IDLE && state != ST_SINK && wait_cnt[0]) begin
				junk     = rand_sample();
				in_valid = 1'b1;
				in_real  = junk[W_DATA-1:0];
				in_imag  = ~junk[W_DATA-1:0];
			end
		end
		in_valid = 1'b0;
		if (got_re.size() < exp_re.size()) begin
			err_count++;
			$display("Timeout: %s got %0d of %0d outputs", name, got_re.size(), exp_re.size());
		end
		// Room for stray extra outputs
		repeat (8) @(negedge clk);
		check_value({name, " count"}, exp_re.size(), got_re.size());
		n_cmp = (got_re.size() < exp_re.size()) ? got_re.size() : exp_re.size();
		for (int i = 0; i < n_cmp; i++) begin
			check_value($sformatf("%s re[%0d]", name, i), exp_re[i], got_re[i]);
			check_value($sformatf("%s im[%0d]", name, i), exp_im[i], got_im[i]);
			check_value($sformatf("%s sop[%0d]", name, i), exp_sop[i], got_sop[i]);
			check_value($sformatf("%s eop[%0d]", name, i), exp_eop[i], got_eop[i]);
		end
		exp_re.delete();
		exp_im.delete();
		exp_sop.delete();
		exp_eop.delete();
		got_re.delete();
		got_im.delete();
		got_sop.delete();
		got_eop.delete();
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("Test %s finished with %0d errors", name, err_count - errs_before);
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic test_reset();
		int errs;
		errs = err_count;
		check_value("reset sink_ready", 1, int'(sink_ready));
		check_value("reset state", int'(ST_IDLE), int'(state));
		check_value("reset out_valid", 0, int'(out_valid));
		report_test("reset", errs);
	endtask

	task automatic test_small();
		int errs;
		errs = err_count;
		fill_random(2);
		model_packet(2);
		send_packet(2, 4);
		drain_and_check("small_4", 1'b0);
		report_test("small_4", errs);
	endtask

	// Saturated blocks stress the guard bit of the core
	task automatic test_full_scale();
		int errs;
		errs = err_count;
		fill_random(6);
		for (int i = 0; i < 16; i++) begin
			pkt_re[i]    = FULL_POS;
			pkt_im[i]    = FULL_NEG;
			pkt_re[i+16] = FULL_NEG;
			pkt_im[i+16] = FULL_POS;
		end
		model_packet(6);
		send_packet(6, 64);
		drain_and_check("full_64", 1'b0);
		report_test("full_64", errs);
	endtask

	task automatic test_back_to_back();
		int errs;
		errs = err_count;
		fill_random(3);
		model_packet(3);
		send_packet(3, 8);
		fill_random(5);
		model_packet(5);
		send_packet(5, 32);
		fill_random(4);
		model_packet(4);
		send_packet(4, 16);
		drain_and_check("b2b_8_32_16", 1'b0);
		report_test("b2b_8_32_16", errs);
	endtask

	task automatic test_dropped();
		int errs;
		int wait_cnt;
		errs = err_count;
		fill_random(4);
		send_packet(4, 5);
		wait_cnt = 0;
		while (!sink_ready && wait_cnt < SINK_TIMEOUT + 8) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!sink_ready) begin
			err_count++;
			$display("Timeout: sink_ready did not return after a partial packet");
		end
		// Idle cycles counted from the first one without a sample
		check_value("dropped idle cycles", SINK_TIMEOUT, wait_cnt);
		repeat (8) @(negedge clk);
		check_value("dropped outputs", 0, got_re.size());
		fill_random(4);
		model_packet(4);
		send_packet(4, 16);
		drain_and_check("after_drop", 1'b0);
		report_test("dropped", errs);
	endtask

	task automatic test_garbage();
		int errs;
		errs = err_count;
		fill_random(5);
		model_packet(5);
		send_packet(5, 32);
		drain_and_check("garbage_32", 1'b1);
		report_test("garbage_32", errs);
	endtask

	initial begin
		seed        = 32'hc789_9680;
		err_count   = 0;
		check_count = 0;
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		in_sop      = 1'b0;
		in_size_log = '0;
		in_real     = '0;
		in_imag     = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		test_reset();
		test_small();
		test_full_scale();
		test_back_to_back();
		test_dropped();
		test_garbage();

		$display("%0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mrd_dft.f
verilog/mrd_pkg.sv
verilog/mrd_ram_bank.sv
verilog/mrd_sink_agu.sv
verilog/mrd_stage_rd.sv
verilog/mrd_stage_wr.sv
verilog/mrd_rdx2_core.sv
verilog/mrd_source_agu.sv
verilog/mrd_mem_top.sv
verilog/mrd_dft_top.sv
test/mrd_dft_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the transform engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
	--top-module mrd_dft_tb \
	-Mdir "$BUILD_DIR" \
	-f mrd_dft.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vmrd_dft_tb" > "$LOG_FILE" 2>&1
SIM_STATUS=$?
cat "$LOG_FILE"
if [ $SIM_STATUS -ne 0 ]; then
	echo "Simulator exited with status $SIM_STATUS"
	exit 1
fi

# Verdict comes from the log
if grep -q "TEST FAIL" "$LOG_FILE"; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST PASS" "$LOG_FILE"; then
	echo "Simulation ended without a verdict"
	exit 1
fi
exit 0
